// File: logic/operand_fwd_if.sv
`default_nettype none
`timescale 1ns/1ps
`include "rv_core_config.svh"

interface operand_fwd_if;

   // instruction in memory stage
   logic                      em_valid;
   logic                      em_writes_rd;
   logic                      em_is_load;
   logic [`RV_REG_ADDR_W-1:0] em_rd;
   logic [`RV_XLEN-1:0]       em_result;

   // instruction in writeback stage
   logic                      mw_valid;
   logic                      mw_writes_rd;
   logic [`RV_REG_ADDR_W-1:0] mw_rd;
   logic [`RV_XLEN-1:0]       mw_result;

   modport producer (
      output em_valid, em_writes_rd, em_is_load, em_rd, em_result,
      output mw_valid, mw_writes_rd, mw_rd, mw_result
   );

   modport consumer (
      input em_valid, em_writes_rd, em_is_load, em_rd, em_result,
      input mw_valid, mw_writes_rd, mw_rd, mw_result
   );

endinterface

`default_nettype wire

// File: logic/rv_core.sv
`default_nettype none
`timescale 1ns/1ps
`include "rv_core_config.svh"

module rv_core
   import rv_core_pkg::*;
(
   input  wire                 clk,
   input  wire                 rstn,
   output logic [`RV_XLEN-1:0] instr_addr,
   input  wire [`RV_XLEN-1:0]  instr_data,
   output logic [`RV_XLEN-1:0] dmem_addr,
   output logic [`RV_XLEN-1:0] dmem_wdata,
   output logic                dmem_we,
   output logic                dmem_re,
   input  wire [`RV_XLEN-1:0]  dmem_rdata,
   output logic [31:0]         retired_count
);

   logic [`RV_XLEN-1:0] pc;
   logic                fd_valid;
   logic                fd_hold;
   logic [`RV_XLEN-1:0] fd_pc;
   logic [`RV_XLEN-1:0] fd_instr;

   rv_decoded_t         id_dec;
   logic [`RV_XLEN-1:0] id_rs1_data;
   logic [`RV_XLEN-1:0] id_rs2_data;
   logic                de_valid;

   rv_decoded_t         de_dec;
   logic [`RV_XLEN-1:0] de_pc;
   logic [`RV_XLEN-1:0] de_rs1_data;
   logic [`RV_XLEN-1:0] de_rs2_data;
   logic                ex_valid;
   logic                ex_hold_bubble;
   logic [`RV_XLEN-1:0] fwd_rs1;
   logic [`RV_XLEN-1:0] fwd_rs2;
   logic [`RV_XLEN-1:0] ex_result;
   logic                ex_jump_taken;
   logic [`RV_XLEN-1:0] ex_jump_target;

   rv_decoded_t         em_dec;
   logic                em_valid;
   logic [`RV_XLEN-1:0] em_result;
   logic [`RV_XLEN-1:0] em_store_data;

   rv_decoded_t         mw_dec;
   logic                mw_valid;
   logic [`RV_XLEN-1:0] mw_result;

   operand_fwd_if fwd ();

   ////////////////////////////////////////////////////////////
   // fetch / decode
   ////////////////////////////////////////////////////////////

   assign instr_addr = pc;

   always_ff @(posedge clk) begin
      if (!fd_hold) begin
         fd_pc    <= pc;
         fd_instr <= instr_data;
      end
   end

   rv_decoder u_decoder (
      .instr_raw (fd_instr),
      .decoded   (id_dec)
   );

   rv_regfile u_regfile (
      .clk      (clk),
      .rstn     (rstn),
      .rs1_addr (id_dec.rs1),
      .rs2_addr (id_dec.rs2),
      .wr_en    (mw_valid && mw_dec.writes_rd),
      .wr_addr  (mw_dec.rd),
      .wr_data  (mw_result),
      .rs1_data (id_rs1_data),
      .rs2_data (id_rs2_data)
   );

   ////////////////////////////////////////////////////////////
   // decode / execute
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (rstn) begin
         ex_valid <= 1'b0;
      end else if (!ex_hold_bubble) begin
         ex_valid <= de_valid;
      end
   end

   // held instruction keeps what was forwarded while it waited
   always_ff @(posedge clk) begin
      if (ex_hold_bubble) begin
         de_rs1_data <= fwd_rs1;
         de_rs2_data <= fwd_rs2;
      end else begin
         de_dec      <= id_dec;
         de_pc       <= fd_pc;
         de_rs1_data <= id_rs1_data;
         de_rs2_data <= id_rs2_data;
      end
   end

   rv_execute u_execute (
      .decoded     (de_dec),
      .pc          (de_pc),
      .op_a        (fwd_rs1),
      .op_b        (fwd_rs2),
      .result      (ex_result),
      .jump_taken  (ex_jump_taken),
      .jump_target (ex_jump_target)
   );

   rv_pipe_ctrl u_pipe_ctrl (
      .clk            (clk),
      .rstn           (rstn),
      .de_decoded     (de_dec),
      .ex_valid       (ex_valid),
      .jump_taken     (ex_jump_taken),
      .jump_target    (ex_jump_target),
      .fwd            (fwd.consumer),
      .rf_rs1_data    (de_rs1_data),
      .rf_rs2_data    (de_rs2_data),
      .pc             (pc),
      .fd_valid       (fd_valid),
      .de_valid       (de_valid),
      .ex_hold_bubble (ex_hold_bubble),
      .fd_hold        (fd_hold),
      .fwd_rs1        (fwd_rs1),
      .fwd_rs2        (fwd_rs2),
      .retired_count  (retired_count)
   );

   ////////////////////////////////////////////////////////////
   // memory / writeback
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (rstn) begin
         em_valid <= 1'b0;
         mw_valid <= 1'b0;
      end else begin
         em_valid <= ex_valid && !ex_hold_bubble;
         mw_valid <= em_valid;
      end
   end

   always_ff @(posedge clk) begin
      em_dec        <= de_dec;
      em_result     <= ex_result;
      em_store_data <= fwd_rs2;
      mw_dec        <= em_dec;
      mw_result     <= em_dec.is_load ? dmem_rdata : em_result;
   end

   assign dmem_addr  = em_result;
   assign dmem_wdata = em_store_data;
   assign dmem_we    = em_valid && em_dec.is_store;
   assign dmem_re    = em_valid && em_dec.is_load;

   // result taps for the controller
   assign fwd.em_valid     = em_valid;
   assign fwd.em_writes_rd = em_dec.writes_rd;
   assign fwd.em_is_load   = em_dec.is_load;
   assign fwd.em_rd        = em_dec.rd;
   assign fwd.em_result    = em_result;
   assign fwd.mw_valid     = mw_valid;
   assign fwd.mw_writes_rd = mw_dec.writes_rd;
   assign fwd.mw_rd        = mw_dec.rd;
   assign fwd.mw_result    = mw_result;

endmodule

`default_nettype wire

// File: logic/rv_core_config.svh
`ifndef RV_CORE_CONFIG_SVH
`define RV_CORE_CONFIG_SVH

// datapath and address width
`define RV_XLEN        32

// integer register file
`define RV_REG_COUNT   32
`define RV_REG_ADDR_W  5

// fetch sequencing
`define RV_RESET_PC    32'h0000_0000
`define RV_PC_STEP     32'd4

`endif

// File: logic/rv_core_pkg.sv
`default_nettype none
`include "rv_core_config.svh"

package rv_core_pkg;

   // supported subset, anything else decodes to OP_ILLEGAL
   typedef enum logic [3:0] {
      OP_ADD,
      OP_SUB,
      OP_ADDI,
      OP_LW,
      OP_SW,
      OP_BEQ,
      OP_JAL,
      OP_ILLEGAL
   } rv_opcode_e;

   typedef enum logic [1:0] {
      ALU_ADD,
      ALU_SUB,
      ALU_PASS_B
   } rv_alu_op_e;

   typedef struct packed {
      rv_opcode_e                opcode;
      rv_alu_op_e                alu_op;
      logic [`RV_REG_ADDR_W-1:0] rs1;
      logic [`RV_REG_ADDR_W-1:0] rs2;
      logic [`RV_REG_ADDR_W-1:0] rd;
      logic [`RV_XLEN-1:0]       imm;
      logic                      uses_rs1;
      logic                      uses_rs2;
      logic                      writes_rd;
      logic                      is_load;
      logic                      is_store;
      logic                      is_branch;
      logic                      is_jump;
   } rv_decoded_t;

endpackage

`default_nettype wire

// File: logic/rv_decoder.sv
`default_nettype none
`timescale 1ns/1ps
`include "rv_core_config.svh"

module rv_decoder
   import rv_core_pkg::*;
(
   input  wire [`RV_XLEN-1:0] instr_raw,
   output rv_decoded_t        decoded
);

   localparam logic [6:0] MAJ_OP     = 7'b0110011;
   localparam logic [6:0] MAJ_OP_IMM = 7'b0010011;
   localparam logic [6:0] MAJ_LOAD   = 7'b0000011;
   localparam logic [6:0] MAJ_STORE  = 7'b0100011;
   localparam logic [6:0] MAJ_BRANCH = 7'b1100011;
   localparam logic [6:0] MAJ_JAL    = 7'b1101111;

   wire [6:0] major  = instr_raw[6:0];
   wire [2:0] funct3 = instr_raw[14:12];
   wire [6:0] funct7 = instr_raw[31:25];

   // sign-extended immediate formats
   wire [`RV_XLEN-1:0] imm_i = {{20{instr_raw[31]}}, instr_raw[31:20]};
   wire [`RV_XLEN-1:0] imm_s = {{20{instr_raw[31]}}, instr_raw[31:25], instr_raw[11:7]};
   wire [`RV_XLEN-1:0] imm_b = {{19{instr_raw[31]}}, instr_raw[31], instr_raw[7],
                                instr_raw[30:25], instr_raw[11:8], 1'b0};
   wire [`RV_XLEN-1:0] imm_j = {{11{instr_raw[31]}}, instr_raw[31], instr_raw[19:12],
                                instr_raw[20], instr_raw[30:21], 1'b0};

   always_comb begin
      decoded        = '0;
      decoded.opcode = OP_ILLEGAL;
      decoded.alu_op = ALU_ADD;
      decoded.rs1    = instr_raw[19:15];
      decoded.rs2    = instr_raw[24:20];
      decoded.rd     = instr_raw[11:7];

      case (major)
         MAJ_OP: begin
            if (funct3 == 3'b000 && funct7 == 7'b0000000) begin
               decoded.opcode = OP_ADD;
            end else if (funct3 == 3'b000 && funct7 == 7'b0100000) begin
               decoded.opcode = OP_SUB;
            end
         end
         MAJ_OP_IMM: if (funct3 == 3'b000) decoded.opcode = OP_ADDI;
         MAJ_LOAD:   if (funct3 == 3'b010) decoded.opcode = OP_LW;
         MAJ_STORE:  if (funct3 == 3'b010) decoded.opcode = OP_SW;
         MAJ_BRANCH: if (funct3 == 3'b000) decoded.opcode = OP_BEQ;
         MAJ_JAL:    decoded.opcode = OP_JAL;
         default:    decoded.opcode = OP_ILLEGAL;
      endcase

      // operand usage and control flags
      case (decoded.opcode)
         OP_ADD: begin
            decoded.uses_rs1  = 1'b1;
            decoded.uses_rs2  = 1'b1;
            decoded.writes_rd = 1'b1;
         end
         OP_SUB: begin
            decoded.alu_op    = ALU_SUB;
            decoded.uses_rs1  = 1'b1;
            decoded.uses_rs2  = 1'b1;
            decoded.writes_rd = 1'b1;
         end
         OP_ADDI: begin
            decoded.imm       = imm_i;
            decoded.uses_rs1  = 1'b1;
            decoded.writes_rd = 1'b1;
         end
         OP_LW: begin
            decoded.imm       = imm_i;
            decoded.uses_rs1  = 1'b1;
            decoded.writes_rd = 1'b1;
            decoded.is_load   = 1'b1;
         end
         OP_SW: begin
            decoded.imm      = imm_s;
            decoded.uses_rs1 = 1'b1;
            decoded.uses_rs2 = 1'b1;
            decoded.is_store = 1'b1;
         end
         OP_BEQ: begin
            // equality comes from a zero difference in execute
            decoded.alu_op    = ALU_SUB;
            decoded.imm       = imm_b;
            decoded.uses_rs1  = 1'b1;
            decoded.uses_rs2  = 1'b1;
            decoded.is_branch = 1'b1;
         end
         OP_JAL: begin
            decoded.alu_op    = ALU_PASS_B;
            decoded.imm       = imm_j;
            decoded.writes_rd = 1'b1;
            decoded.is_jump   = 1'b1;
         end
         default: decoded.writes_rd = 1'b0;
      endcase

      if (decoded.rd == '0) begin
         decoded.writes_rd = 1'b0;
      end
   end

endmodule

`default_nettype wire

// File: logic/rv_execute.sv
`default_nettype none
`timescale 1ns/1ps
`include "rv_core_config.svh"

module rv_execute
   import rv_core_pkg::*;
(
   input  wire rv_decoded_t    decoded,
   input  wire [`RV_XLEN-1:0]  pc,
   input  wire [`RV_XLEN-1:0]  op_a,
   input  wire [`RV_XLEN-1:0]  op_b,
   output logic [`RV_XLEN-1:0] result,
   output logic                jump_taken,
   output logic [`RV_XLEN-1:0] jump_target
);

   logic [`RV_XLEN-1:0] link;
   logic [`RV_XLEN-1:0] src_b;

   assign link = pc + `RV_PC_STEP;

   // second ALU source
   always_comb begin
      case (decoded.opcode)
         OP_ADDI, OP_LW, OP_SW: src_b = decoded.imm;
         OP_JAL:                src_b = link;
         default:               src_b = op_b;
      endcase
   end

   always_comb begin
      case (decoded.alu_op)
         ALU_SUB:    result = op_a - src_b;
         ALU_PASS_B: result = src_b;
         default:    result = op_a + src_b;
      endcase
   end

   // BEQ subtracts, so a zero result means equal
   assign jump_taken  = decoded.is_jump || (decoded.is_branch && result == '0);
   assign jump_target = pc + decoded.imm;

endmodule

`default_nettype wire

// File: logic/rv_pipe_ctrl.sv
`default_nettype none
`timescale 1ns/1ps
`include "rv_core_config.svh"

module rv_pipe_ctrl
   import rv_core_pkg::*;
(
   input  wire                  clk,
   input  wire                  rstn,
   input  wire rv_decoded_t     de_decoded,
   input  wire                  ex_valid,
   input  wire                  jump_taken,
   input  wire [`RV_XLEN-1:0]   jump_target,
   operand_fwd_if.consumer      fwd,
   input  wire [`RV_XLEN-1:0]   rf_rs1_data,
   input  wire [`RV_XLEN-1:0]   rf_rs2_data,
   output logic [`RV_XLEN-1:0]  pc,
   output logic                 fd_valid,
   output logic                 de_valid,
   output logic                 ex_hold_bubble,
   output logic                 fd_hold,
   output logic [`RV_XLEN-1:0]  fwd_rs1,
   output logic [`RV_XLEN-1:0]  fwd_rs2,
   output logic [31:0]          retired_count
);

   logic rs1_em;
   logic rs1_mw;
   logic rs2_em;
   logic rs2_mw;
   logic load_use;
   logic flush;

   function automatic logic tap_hit(input logic                      uses,
                                    input logic [`RV_REG_ADDR_W-1:0] rs,
                                    input logic                      valid,
                                    input logic                      writes,
                                    input logic [`RV_REG_ADDR_W-1:0] rd);
      return uses && valid && writes && (rs != '0) && (rs == rd);
   endfunction

   ////////////////////////////////////////////////////////////
   // forwarding into execute
   ////////////////////////////////////////////////////////////

   always_comb begin
      rs1_em = tap_hit(de_decoded.uses_rs1, de_decoded.rs1,
                       fwd.em_valid, fwd.em_writes_rd, fwd.em_rd);
      rs1_mw = tap_hit(de_decoded.uses_rs1, de_decoded.rs1,
                       fwd.mw_valid, fwd.mw_writes_rd, fwd.mw_rd);
      rs2_em = tap_hit(de_decoded.uses_rs2, de_decoded.rs2,
                       fwd.em_valid, fwd.em_writes_rd, fwd.em_rd);
      rs2_mw = tap_hit(de_decoded.uses_rs2, de_decoded.rs2,
                       fwd.mw_valid, fwd.mw_writes_rd, fwd.mw_rd);
   end

   // nearest producer wins
   assign fwd_rs1 = rs1_em ? fwd.em_result :
                    rs1_mw ? fwd.mw_result : rf_rs1_data;
   assign fwd_rs2 = rs2_em ? fwd.em_result :
                    rs2_mw ? fwd.mw_result : rf_rs2_data;

   ////////////////////////////////////////////////////////////
   // hazards
   ////////////////////////////////////////////////////////////

   // load data only exists once the load reaches writeback
   assign load_use = ex_valid && fwd.em_is_load && (rs1_em || rs2_em);

   // a branch reading stale load data must not resolve yet
   assign flush = ex_valid && jump_taken && !load_use;

   assign fd_hold        = load_use;
   assign ex_hold_bubble = load_use;
   assign de_valid       = fd_valid && !flush;

   always_ff @(posedge clk) begin
      if (rstn) begin
         pc       <= `RV_RESET_PC;
         fd_valid <= 1'b0;
      end else if (flush) begin
         pc       <= jump_target;
         fd_valid <= 1'b0;
      end else if (!load_use) begin
         pc       <= pc + `RV_PC_STEP;
         fd_valid <= 1'b1;
      end
   end

   // every valid instruction leaving writeback
   always_ff @(posedge clk) begin
      if (rstn) begin
         retired_count <= '0;
      end else if (fwd.mw_valid) begin
         retired_count <= retired_count + 32'd1;
      end
   end

endmodule

`default_nettype wire

// File: logic/rv_regfile.sv
`default_nettype none
`timescale 1ns/1ps
`include "rv_core_config.svh"

module rv_regfile (
   input  wire                      clk,
   input  wire                      rstn,
   input  wire [`RV_REG_ADDR_W-1:0] rs1_addr,
   input  wire [`RV_REG_ADDR_W-1:0] rs2_addr,
   input  wire                      wr_en,
   input  wire [`RV_REG_ADDR_W-1:0] wr_addr,
   input  wire [`RV_XLEN-1:0]       wr_data,
   output logic [`RV_XLEN-1:0]      rs1_data,
   output logic [`RV_XLEN-1:0]      rs2_data
);

   logic [`RV_XLEN-1:0] regs [`RV_REG_COUNT];

   // write-first, x0 hardwired
   function automatic logic [`RV_XLEN-1:0] read_port(input logic [`RV_REG_ADDR_W-1:0] addr);
      if (addr == '0) begin
         return '0;
      end else if (wr_en && wr_addr == addr) begin
         return wr_data;
      end
      return regs[addr];
   endfunction

   always_ff @(posedge clk) begin
      if (rstn) begin
         for (int i = 0; i < `RV_REG_COUNT; i++) begin
            regs[i] <= '0;
         end
      end else if (wr_en && wr_addr != '0) begin
         regs[wr_addr] <= wr_data;
      end
   end

   always_comb begin
      rs1_data = read_port(rs1_addr);
      rs2_data = read_port(rs2_addr);
   end

endmodule

`default_nettype wire

// File: rv_core.f
+incdir+logic
logic/rv_core_pkg.sv
logic/operand_fwd_if.sv
logic/rv_decoder.sv
logic/rv_regfile.sv
logic/rv_execute.sv
logic/rv_pipe_ctrl.sv
logic/rv_core.sv
tb/rv_core_sva.sv
tb/rv_core_tb.sv

// File: tb/rv_core_sva.sv
`default_nettype none
`timescale 1ns/1ps
`include "rv_core_config.svh"

module rv_core_sva (
   input wire                clk,
   input wire                rstn,
   input wire [`RV_XLEN-1:0] instr_addr,
   input wire                dmem_we,
   input wire                dmem_re,
   input wire [31:0]         retired_count
);

   // one memory access per cycle, load or store
   a_single_strobe: assert property (@(posedge clk) disable iff (rstn)
      !(dmem_we && dmem_re))
      else $error("dmem_we and dmem_re high in the same cycle");

   // memory stage is empty right after a reset edge
   a_quiet_after_reset: assert property (@(posedge clk)
      rstn |=> !dmem_we && !dmem_re)
      else $error("memory strobe active in the cycle after reset");

   a_retire_monotonic: assert property (@(posedge clk) disable iff (rstn)
      !$past(rstn) |-> retired_count >= $past(retired_count))
      else $error("retired_count decreased outside reset");

   // fetch stays word aligned, jumps included
   a_fetch_aligned: assert property (@(posedge clk) disable iff (rstn)
      instr_addr[1:0] == 2'b00)
      else $error("instr_addr %h is not word aligned", instr_addr);

endmodule

`default_nettype wire

// File: tb/rv_core_tb.sv
`default_nettype none
`timescale 1ns/1ps
`include "rv_core_config.svh"

module rv_core_tb
   import rv_core_pkg::*;
();

   localparam int CLK_PERIOD   = 4;
   localparam int RESET_CYCLES = 2;
   localparam int NUM_TESTS    = 6;
   localparam int MAX_INSTR    = 8;
   localparam int BUDGET       = 40;
   localparam int MEM_WORDS    = 64;
   localparam int WATCHDOG_NS  = NUM_TESTS * (RESET_CYCLES + BUDGET + 10) * CLK_PERIOD;
   localparam logic [31:0] NOP = 32'h0000_0013;

   typedef struct packed {
      rv_opcode_e                op;
      logic [`RV_REG_ADDR_W-1:0] rd;
      logic [`RV_REG_ADDR_W-1:0] rs1;
      logic [`RV_REG_ADDR_W-1:0] rs2;
      logic [`RV_XLEN-1:0]       imm;
   } instr_t;

   logic                clk;
   logic                rstn;
   logic [`RV_XLEN-1:0] instr_addr;
   logic [`RV_XLEN-1:0] instr_data;
   logic [`RV_XLEN-1:0] dmem_addr;
   logic [`RV_XLEN-1:0] dmem_wdata;
   logic                dmem_we;
   logic                dmem_re;
   logic [`RV_XLEN-1:0] dmem_rdata;
   logic [31:0]         retired_count;

   logic [`RV_XLEN-1:0] rom [MEM_WORDS];
   logic [`RV_XLEN-1:0] ram [MEM_WORDS];

   // program table and expected results per row
   instr_t              prog [NUM_TESTS][MAX_INSTR];
   int                  n_instr [NUM_TESTS];
   string               test_name [NUM_TESTS];
   logic [`RV_XLEN-1:0] exp_addr [NUM_TESTS];
   logic [`RV_XLEN-1:0] exp_data [NUM_TESTS];
   int                  exp_stores [NUM_TESTS];
   logic [31:0]         exp_retired [NUM_TESTS];

   logic [31:0]         rng_state;
   int                  errors;
   int                  failed_tests;

   rv_core uut (
      .clk           (clk),
      .rstn          (rstn),
      .instr_addr    (instr_addr),
      .instr_data    (instr_data),
      .dmem_addr     (dmem_addr),
      .dmem_wdata    (dmem_wdata),
      .dmem_we       (dmem_we),
      .dmem_re       (dmem_re),
      .dmem_rdata    (dmem_rdata),
      .retired_count (retired_count)
   );

   bind rv_core rv_core_sva u_sva (
      .clk           (clk),
      .rstn          (rstn),
      .instr_addr    (instr_addr),
      .dmem_we       (dmem_we),
      .dmem_re       (dmem_re),
      .retired_count (retired_count)
   );

   ////////////////////////////////////////////////////////////
   // memory models with combinational read
   ////////////////////////////////////////////////////////////

   assign instr_data = rom[instr_addr[7:2]];
   assign dmem_rdata = ram[dmem_addr[7:2]];

   always @(posedge clk) begin
      if (dmem_we) begin
         ram[dmem_addr[7:2]] <= dmem_wdata;
      end
   end

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   initial begin
      #(WATCHDOG_NS);
      $display("watchdog expired after %0d ns, the run did not complete", WATCHDOG_NS);
      $display("Something failed");
      $finish;
   end

   function automatic logic [31:0] xorshift();
      rng_state = rng_state ^ (rng_state << 13);
      rng_state = rng_state ^ (rng_state >> 17);
      rng_state = rng_state ^ (rng_state << 5);
      return rng_state;
   endfunction

   // fits the 12-bit I and S immediates
   function automatic logic [31:0] rand_imm();
      logic [31:0] r;
      r = xorshift();
      return {{21{r[10]}}, r[10:0]};
   endfunction

   function automatic logic [31:0] encode(input instr_t i);
      case (i.op)
         OP_ADD:  return {7'b0000000, i.rs2, i.rs1, 3'b000, i.rd, 7'b0110011};
         OP_SUB:  return {7'b0100000, i.rs2, i.rs1, 3'b000, i.rd, 7'b0110011};
         OP_ADDI: return {i.imm[11:0], i.rs1, 3'b000, i.rd, 7'b0010011};
         OP_LW:   return {i.imm[11:0], i.rs1, 3'b010, i.rd, 7'b0000011};
         OP_SW:   return {i.imm[11:5], i.rs2, i.rs1, 3'b010, i.imm[4:0], 7'b0100011};
         OP_BEQ:  return {i.imm[12], i.imm[10:5], i.rs2, i.rs1, 3'b000,
                          i.imm[4:1], i.imm[11], 7'b1100011};
         OP_JAL:  return {i.imm[20], i.imm[10:1], i.imm[11], i.imm[19:12],
                          i.rd, 7'b1101111};
         default: return NOP;
      endcase
   endfunction

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] expected);
      if (got !== expected) begin
         $display("** Error at %0t ns: %s = %h, expected %h", $time, name, got, expected);
         errors++;
      end
   endtask

   task automatic add_instr(input int row, input rv_opcode_e op,
                            input logic [4:0] rd, input logic [4:0] rs1,
                            input logic [4:0] rs2, input logic [31:0] imm);
      int k;
      k = n_instr[row];
      prog[row][k].op  = op;
      prog[row][k].rd  = rd;
      prog[row][k].rs1 = rs1;
      prog[row][k].rs2 = rs2;
      prog[row][k].imm = imm;
      n_instr[row] = k + 1;
   endtask

   task automatic set_expect(input int row, input string name, input logic [31:0] addr,
                             input logic [31:0] data, input int stores,
                             input logic [31:0] retired);
      test_name[row]   = name;
      exp_addr[row]    = addr;
      exp_data[row]    = data;
      exp_stores[row]  = stores;
      exp_retired[row] = retired;
   endtask

   ////////////////////////////////////////////////////////////
   // programs
   ////////////////////////////////////////////////////////////

   task automatic build_table();
      logic [31:0] a;
      logic [31:0] b;
      logic [31:0] c;
      foreach (n_instr[r]) begin
         n_instr[r] = 0;
      end

      // every instruction reads the one just before it
      a = rand_imm();
      b = rand_imm();
      add_instr(0, OP_ADDI, 1, 0, 0, a);
      add_instr(0, OP_ADDI, 2, 1, 0, b);
      add_instr(0, OP_ADD,  3, 2, 2, 0);
      add_instr(0, OP_SUB,  4, 3, 1, 0);
      add_instr(0, OP_SW,   0, 0, 4, 32'h40);
      set_expect(0, "fwd_one_step", 32'h40, a + b + b, 1, 5);

      // one unrelated instruction between producer and consumer
      a = rand_imm();
      b = rand_imm();
      c = rand_imm();
      add_instr(1, OP_ADDI, 5, 0, 0, a);
      add_instr(1, OP_ADDI, 6, 0, 0, b);
      add_instr(1, OP_ADDI, 7, 5, 0, c);
      add_instr(1, OP_ADDI, 8, 0, 0, 32'd1);
      add_instr(1, OP_SW,   0, 0, 7, 32'h44);
      set_expect(1, "fwd_two_step", 32'h44, a + c, 1, 5);

      a = rand_imm();
      b = rand_imm();
      add_instr(2, OP_ADDI, 4, 0, 0, b);
      add_instr(2, OP_ADDI, 1, 0, 0, a);
      add_instr(2, OP_SW,   0, 0, 1, 32'h48);
      add_instr(2, OP_LW,   2, 0, 0, 32'h48);
      add_instr(2, OP_ADD,  3, 2, 4, 0);
      add_instr(2, OP_SW,   0, 0, 3, 32'h4c);
      set_expect(2, "load_use", 32'h4c, a + b, 2, 6);

      // equal operands so the branch skips two stores
      a = rand_imm();
      add_instr(3, OP_ADDI, 1, 0, 0, a);
      add_instr(3, OP_ADDI, 2, 0, 0, a);
      add_instr(3, OP_BEQ,  0, 1, 2, 32'd12);
      add_instr(3, OP_SW,   0, 0, 1, 32'h50);
      add_instr(3, OP_SW,   0, 0, 1, 32'h54);
      add_instr(3, OP_SW,   0, 0, 2, 32'h58);
      set_expect(3, "beq_taken", 32'h58, a, 1, 4);

      a = rand_imm();
      add_instr(4, OP_ADDI, 1, 0, 0, a);
      add_instr(4, OP_ADDI, 2, 1, 0, 32'd1);
      add_instr(4, OP_BEQ,  0, 1, 2, 32'd12);
      add_instr(4, OP_SW,   0, 0, 1, 32'h50);
      add_instr(4, OP_SW,   0, 0, 2, 32'h54);
      add_instr(4, OP_SW,   0, 0, 1, 32'h58);
      set_expect(4, "beq_not_taken", 32'h58, a, 3, 6);

      // JAL at pc 4 skips one store and ADDI leaves x0 at zero
      a = rand_imm();
      b = rand_imm();
      add_instr(5, OP_ADDI, 1, 0, 0, a);
      add_instr(5, OP_JAL,  5, 0, 0, 32'd8);
      add_instr(5, OP_SW,   0, 0, 1, 32'h60);
      add_instr(5, OP_ADDI, 0, 0, 0, b);
      add_instr(5, OP_ADD,  6, 5, 0, 0);
      add_instr(5, OP_SW,   0, 0, 6, 32'h64);
      set_expect(5, "jal_link", 32'h64, 32'd4 + 32'd4, 1, 5);
   endtask

   task automatic run_test(input int row);
      int          cycles;
      int          stores;
      int          loads;
      int          exp_loads;
      int          errors_before;
      errors_before = errors;
      cycles        = 0;
      stores        = 0;
      loads         = 0;
      exp_loads     = 0;
      for (int i = 0; i < n_instr[row]; i++) begin
         if (prog[row][i].op == OP_LW) begin
            exp_loads++;
         end
      end

      @(posedge clk);
      #1;
      rstn = 1'b1;
      for (int i = 0; i < MEM_WORDS; i++) begin
         if (i < n_instr[row]) begin
            rom[i] = encode(prog[row][i]);
         end else begin
            rom[i] = NOP;
         end
         ram[i] = '0;
      end
      repeat (RESET_CYCLES) @(posedge clk);
      #1;
      rstn = 1'b0;
      check_value("instr_addr", instr_addr, `RV_RESET_PC);
      check_value("retired_count", retired_count, 32'd0);

      while (stores < exp_stores[row] && cycles < BUDGET) begin
         @(negedge clk);
         if (dmem_re) begin
            loads++;
         end
         if (dmem_we) begin
            stores++;
            if (stores == exp_stores[row]) begin
               check_value("dmem_addr", dmem_addr, exp_addr[row]);
               check_value("dmem_wdata", dmem_wdata, exp_data[row]);
            end
         end
         cycles++;
      end

      if (stores < exp_stores[row]) begin
         $display("test %0d: saw %0d of %0d stores within %0d cycles",
                  row, stores, exp_stores[row], BUDGET);
         errors++;
      end else begin
         check_value("dmem_re cycles", loads, exp_loads);
         // final store leaves writeback two edges later
         repeat (2) @(posedge clk);
         @(negedge clk);
         check_value("retired_count", retired_count, exp_retired[row]);
      end

      if (errors != errors_before) begin
         failed_tests++;
      end
      $display("test %0d %s: %s", row, test_name[row],
               (errors == errors_before) ? "pass" : "fail");
   endtask

   initial begin
      rstn         = 1'b1;
      rng_state    = 32'd57;
      errors       = 0;
      failed_tests = 0;
      for (int i = 0; i < MEM_WORDS; i++) begin
         rom[i] = NOP;
         ram[i] = '0;
      end
      build_table();

      for (int row = 0; row < NUM_TESTS; row++) begin
         run_test(row);
      end

      $display("tests %0d, failed %0d, errors %0d", NUM_TESTS, failed_tests, errors);
      if (errors == 0) begin
         $display("Everything OK");
      end else begin
         $display("Something failed");
      end
      $finish;
   end

endmodule

`default_nettype wire
